// ==== tb.f ====
+incdir+verilog
verilog/gf_pkg.sv
verilog/bch_pkg.sv
verilog/bch_syndrome.sv
verilog/bch_key_bma.sv
verilog/bch_chien_cell.sv
verilog/bch_correct.sv
verilog/bch_decoder.sv
bench/bch_decoder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP := bch_decoder_tb
FILELIST := tb.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/bch_decoder_tb.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_decoder_tb import bch_pkg::*;;

	typedef logic [`BCH_K-1:0] msg_t;

	localparam int WAIT_LIMIT = 200; // Cycles per wait
	localparam int NUM_VEC = 11;
	localparam int NUM_RANDOM = 40;

	// Message, error mask and expected count per entry
	// A count of 3 leaves the result to the reference model
	localparam msg_t VEC_MSG [NUM_VEC] = '{7'h00, 7'h55, 7'h2a, 7'h7f, 7'h13, 7'h6c,
		7'h01, 7'h40, 7'h3c, 7'h5a, 7'h00};
	localparam codeword_t VEC_MASK [NUM_VEC] = '{15'h0000, 15'h0000, 15'h0001, 15'h4000,
		15'h0100, 15'h4001, 15'h0018, 15'h2200, 15'h0007, 15'h4a10, 15'h7000};
	localparam int VEC_CNT [NUM_VEC] = '{0, 0, 1, 1, 1, 2, 2, 2, 3, 3, 3};

	logic clk;
	logic rst_n;
	logic in_start;
	codeword_t in_word;
	logic in_busy;
	logic out_valid;
	codeword_t out_word;
	err_count_t out_err_count;
	logic out_fail;

	int errors = 0;
	int tests_run = 0;
	int valid_seen = 0;
	logic aborted = 1'b0;

	bch_decoder uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_start(in_start),
		.in_word(in_word),
		.in_busy(in_busy),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_err_count(out_err_count),
		.out_fail(out_fail)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(negedge clk) begin
		if (out_valid)
			valid_seen++; // Counts every result pulse
	end

	// ==================================================
	// Reference encoder and nearest-codeword model
	// ==================================================

	// Systematic encoder over g(x) = x^8 + x^7 + x^6 + x^4 + 1
	function automatic codeword_t encode(msg_t msg);
		codeword_t r;
		r = {msg, {(`BCH_N-`BCH_K){1'b0}}};
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--)
			if (r[i])
				r[i -: 9] ^= 9'b1_1101_0001;
		return {msg, r[`BCH_N-`BCH_K-1:0]};
	endfunction

	task automatic nearest(input codeword_t rx, output codeword_t w, output int cnt,
		output logic fail);
		codeword_t c;
		int d;
		w = rx;
		cnt = 0;
		fail = 1'b1;
		for (int m = 0; m < (1 << `BCH_K); m++) begin
			c = encode(msg_t'(m));
			d = $countones(c ^ rx);
			if (d <= 2) begin
				w = c;
				cnt = d;
				fail = 1'b0;
			end
		end
	endtask

	// ==================================================
	// Waits and one decode
	// ==================================================
	task automatic wait_not_busy(output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			ok = !in_busy;
			cycles++;
		end
		if (!ok)
			$display("Timeout: in_busy stayed high for %0d cycles", WAIT_LIMIT);
	endtask

	task automatic wait_result(output logic ok);
		int cycles;
		logic busy_reported;
		ok = 1'b0;
		cycles = 0;
		busy_reported = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			ok = out_valid;
			if (!busy_reported) begin
				assert (ok || in_busy) else begin
					$display("in_busy dropped at %0t before the result was out", $time);
					errors++;
					busy_reported = 1'b1;
				end
			end
			cycles++;
		end
		if (!ok)
			$display("Timeout: no out_valid within %0d cycles", WAIT_LIMIT);
	endtask

	task automatic run_test(input msg_t msg, input codeword_t mask, input int tbl_cnt);
		codeword_t rx;
		codeword_t exp_word;
		int exp_cnt;
		logic exp_fail;
		logic ok;
		int errs_before;
		rx = encode(msg) ^ mask;
		if (tbl_cnt <= 2) begin
			exp_word = encode(msg);
			exp_cnt = tbl_cnt;
			exp_fail = 1'b0;
		end else begin
			nearest(rx, exp_word, exp_cnt, exp_fail);
		end
		wait_not_busy(ok);
		if (!ok) begin
			aborted = 1'b1;
			return;
		end
		@(posedge clk);
		in_start <= 1'b1;
		in_word <= rx;
		@(posedge clk);
		in_start <= 1'b0;
		wait_result(ok);
		if (!ok) begin
			aborted = 1'b1;
			return;
		end
		errs_before = errors;
		assert (out_word === exp_word) else begin
			$display("error: time %0t out_word got %h expected %h", $time, out_word, exp_word);
			errors++;
		end
		assert (out_fail === exp_fail) else begin
			$display("error: time %0t out_fail got %b expected %b", $time, out_fail, exp_fail);
			errors++;
		end
		if (!exp_fail) begin
			assert (out_err_count === err_count_t'(exp_cnt)) else begin
				$display("error: time %0t out_err_count got %0d expected %0d",
					$time, out_err_count, exp_cnt);
				errors++;
			end
		end
		tests_run++;
		$display("test %0d: rx %h mask %h %s", tests_run, rx, mask,
			(errors == errs_before) ? "ok" : "mismatch");
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		msg_t msg;
		codeword_t mask;
		int nerr;
		void'($urandom(32'h42a395dd));
		rst_n <= 1'b0;
		in_start <= 1'b0;
		in_word <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Idle after reset
		repeat (5) begin
			@(negedge clk);
			assert (!out_valid && !in_busy) else begin
				$display("out_valid or in_busy went high after reset without a start");
				errors++;
			end
		end

		for (int k = 0; k < NUM_VEC; k++)
			if (!aborted)
				run_test(VEC_MSG[k], VEC_MASK[k], VEC_CNT[k]);

		for (int p = 0; p < `BCH_N; p++) // Every single-error position
			if (!aborted)
				run_test(msg_t'($urandom % (1 << `BCH_K)), codeword_t'(1) << p, 1);

		for (int p = 0; p < `BCH_N - 1; p++) // Pairs with the top bit
			if (!aborted)
				run_test(msg_t'($urandom % (1 << `BCH_K)),
					(codeword_t'(1) << p) | (codeword_t'(1) << (`BCH_N - 1)), 2);

		for (int k = 0; k < NUM_RANDOM; k++) begin
			if (!aborted) begin
				msg = msg_t'($urandom % (1 << `BCH_K));
				nerr = int'($urandom % 4);
				mask = '0;
				while ($countones(mask) < nerr)
					mask[$urandom % `BCH_N] = 1'b1;
				run_test(msg, mask, (nerr <= 2) ? nerr : 3);
			end
		end

		if (!aborted) begin
			repeat (4) @(negedge clk);
			assert (valid_seen == tests_run) else begin
				$display("Saw %0d out_valid pulses for %0d words", valid_seen, tests_run);
				errors++;
			end
		end

		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0 && !aborted)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog/bch_decoder.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_decoder import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_start,
	input codeword_t in_word,
	output logic in_busy,
	output logic out_valid,
	output codeword_t out_word,
	output err_count_t out_err_count,
	output logic out_fail
);

	logic syn_valid;
	syndromes_t syndromes;
	sigma_t sigma;
	err_count_t err_count;
	logic bma_done;
	logic accepted;
	logic chien_load;
	logic chien_step;
	gf_elem_t [`BCH_T-1:0] terms;
	codeword_t word_q; // Received word, held for the correction unit
	logic busy_q;

	assign in_busy = busy_q;

	always_ff @(posedge clk) begin
		if (in_start)
			word_q <= in_word;
	end

	// Busy from start until the result leaves
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy_q <= 1'b0;
		else if (in_start)
			busy_q <= 1'b1;
		else if (out_valid)
			busy_q <= 1'b0;
	end

	bch_syndrome u_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.start(in_start),
		.word(in_word),
		.syn_valid(syn_valid),
		.syndromes(syndromes)
	);

	bch_key_bma u_key (
		.clk(clk),
		.rst_n(rst_n),
		.start(syn_valid),
		.accepted(accepted),
		.syndromes(syndromes),
		.sigma(sigma),
		.errors_present(),
		.busy(),
		.done(bma_done),
		.err_count(err_count)
	);

	// ==================================================
	// Chien terms sigma1..sigmaT
	// ==================================================
	for (genvar j = 1; j <= `BCH_T; j++) begin : g_chien
		bch_chien_cell #(.POWER(j)) u_cell (
			.clk(clk),
			.rst_n(rst_n),
			.load(chien_load),
			.step(chien_step),
			.coef(sigma[j*`BCH_M +: `BCH_M]),
			.term(terms[j-1])
		);
	end

	bch_correct u_correct (
		.clk(clk),
		.rst_n(rst_n),
		.done(bma_done),
		.sigma(sigma),
		.err_count(err_count),
		.word(word_q),
		.accepted(accepted),
		.chien_load(chien_load),
		.chien_step(chien_step),
		.terms(terms),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_err_count(out_err_count),
		.out_fail(out_fail)
	);

endmodule

// ==== verilog/bch_correct.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_correct import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic done,
	input sigma_t sigma,
	input err_count_t err_count,
	input codeword_t word,
	output logic accepted,
	output logic chien_load,
	output logic chien_step,
	input gf_elem_t [`BCH_T-1:0] terms,
	output logic out_valid,
	output codeword_t out_word,
	output err_count_t out_err_count,
	output logic out_fail
);

	localparam int POS_W = $clog2(`BCH_N);
	localparam int CNT_W = $clog2(`BCH_N + 1);

	logic searching;
	logic [POS_W-1:0] pos; // Position i under evaluation
	logic [CNT_W-1:0] root_cnt;
	logic [CNT_W-1:0] roots_total;
	logic last_pos;
	logic root_now;
	logic fail_now;
	gf_elem_t sigma0_q;
	gf_elem_t eval;
	err_count_t count_q;
	codeword_t word_q;
	codeword_t flips;
	codeword_t flip_now;

	assign chien_load = accepted; // Cells copy sigma while it is still held
	assign chien_step = searching;
	assign last_pos = pos == POS_W'(`BCH_N - 1);

	// Locator value at alpha^i, a root marks bit (n - i) mod n
	always_comb begin
		int loc;
		eval = sigma0_q;
		for (int j = 0; j < `BCH_T; j++)
			eval ^= terms[j];
		root_now = eval == '0;
		loc = (pos == '0) ? 0 : `BCH_N - int'(pos);
		flip_now = '0;
		flip_now[loc] = root_now;
		roots_total = root_cnt + CNT_W'(root_now);
		fail_now = roots_total != CNT_W'(count_q);
	end

	// ==================================================
	// Search sequencing
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			accepted <= 1'b0;
			searching <= 1'b0;
			pos <= '0;
			root_cnt <= '0;
			out_valid <= 1'b0;
			out_fail <= 1'b0;
			out_err_count <= '0;
		end else begin
			accepted <= done && !searching && !accepted;
			out_valid <= 1'b0;
			if (accepted) begin
				searching <= 1'b1;
				pos <= '0;
				root_cnt <= '0;
			end else if (searching) begin
				pos <= pos + 1'b1;
				root_cnt <= roots_total;
				if (last_pos) begin
					searching <= 1'b0;
					out_valid <= 1'b1;
					out_fail <= fail_now;
					out_err_count <= count_q;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accepted) begin
			word_q <= word;
			sigma0_q <= sigma[`BCH_M-1:0];
			count_q <= err_count;
			flips <= '0;
		end else if (searching) begin
			flips <= flips ^ flip_now;
			if (last_pos)
				out_word <= fail_now ? word_q : word_q ^ flips ^ flip_now; // Uncorrected on failure
		end
	end

endmodule

// ==== verilog/bch_chien_cell.sv ====
`timescale 1ns/1ps

module bch_chien_cell import gf_pkg::*; #(
	parameter int POWER = 1 // alpha exponent applied per step
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step,
	input gf_elem_t coef,
	output gf_elem_t term
);

	localparam gf_elem_t MULT = gf_alpha_pow(POWER);

	// After i steps the term is coef * alpha^(POWER*i)
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			term <= '0;
		else if (load)
			term <= coef;
		else if (step)
			term <= gf_mul(term, MULT);
	end

endmodule

// ==== verilog/bch_key_bma.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_key_bma import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic accepted,
	input syndromes_t syndromes,
	output sigma_t sigma,
	output logic errors_present, // Valid in the start cycle
	output logic busy,
	output logic done,
	output err_count_t err_count // Valid from done until accepted
);

	localparam int ITER_W = ($clog2(`BCH_T) > 0) ? $clog2(`BCH_T) : 1;
	localparam gf_elem_t GF_ONE = gf_elem_t'(1);
	localparam gf_elem_t GF_ZERO = gf_elem_t'(0);

	bma_state_t state;
	logic [ITER_W-1:0] iter;
	gf_elem_t [`BCH_T:0] sig; // Locator, sigma0 at index 0
	gf_elem_t [`BCH_T:0] lambda; // Correction term
	gf_elem_t [`BCH_T:0] sig_next;
	gf_elem_t gamma; // Last nonzero discrepancy
	gf_elem_t delta; // Registered discrepancy
	gf_elem_t disc;
	err_count_t deg;
	logic last_iter;

	assign errors_present = start && |syndromes;
	assign busy = (start || state != BMA_IDLE) && !accepted;
	assign sigma = sig;
	assign err_count = deg;
	assign last_iter = iter == ITER_W'(`BCH_T - 1);

	// Discrepancy for odd step 2*iter+1, skipping syndromes below S1
	always_comb begin
		int idx;
		disc = '0;
		for (int i = 0; i <= `BCH_T; i++) begin
			idx = 2 * int'(iter) + 1 - i;
			if (idx >= 1)
				disc ^= gf_mul(sig[i], syndromes[(idx-1)*`BCH_M +: `BCH_M]);
		end
	end

	// sigma <- gamma*sigma + delta*x*lambda
	always_comb begin
		sig_next[0] = gf_mul(gamma, sig[0]);
		for (int j = 1; j <= `BCH_T; j++)
			sig_next[j] = gf_mul(gamma, sig[j]) ^ gf_mul(delta, lambda[j-1]);
	end

	// ==================================================
	// Control
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= BMA_IDLE;
			iter <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				BMA_IDLE: begin
					if (start) begin
						iter <= '0;
						state <= BMA_ITERATE;
					end
				end
				BMA_ITERATE: state <= BMA_UPDATE;
				BMA_UPDATE: begin
					if (last_iter) begin
						state <= BMA_HOLD;
						done <= 1'b1;
					end else begin
						iter <= iter + 1'b1;
						state <= BMA_ITERATE;
					end
				end
				BMA_HOLD: if (accepted) state <= BMA_IDLE;
				default: state <= BMA_IDLE;
			endcase
		end
	end

	// ==================================================
	// Datapath
	// ==================================================
	always_ff @(posedge clk) begin
		case (state)
			BMA_IDLE: begin
				if (start) begin
					sig <= '0;
					sig[0] <= GF_ONE;
					lambda <= '0;
					lambda[0] <= GF_ONE;
					gamma <= GF_ONE;
					deg <= '0;
				end
			end
			BMA_ITERATE: delta <= disc;
			BMA_UPDATE: begin
				sig <= sig_next;
				if (delta != GF_ZERO && deg <= iter) begin
					lambda <= {sig[`BCH_T-1:0], GF_ZERO}; // x * old sigma
					deg <= err_count_t'({iter, 1'b1}) - deg;
					gamma <= delta;
				end else begin
					// Even step has zero discrepancy in a binary code
					lambda <= {lambda[`BCH_T-2:0], GF_ZERO, GF_ZERO};
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/bch_syndrome.sv ====
`timescale 1ns/1ps
`include "bch_macros.svh"

module bch_syndrome import gf_pkg::*, bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input codeword_t word,
	output logic syn_valid,
	output syndromes_t syndromes
);

	syndromes_t syn_next;

	// S_j = sum of alpha^(j*i) over set bits i
	always_comb begin
		syn_next = '0;
		for (int j = 1; j <= 2 * `BCH_T; j++) begin
			for (int i = 0; i < `BCH_N; i++) begin
				if (word[i])
					syn_next[(j-1)*`BCH_M +: `BCH_M] ^= gf_alpha_pow(j * i);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			syn_valid <= 1'b0;
		else
			syn_valid <= start; // One cycle behind start
	end

	always_ff @(posedge clk) begin
		if (start)
			syndromes <= syn_next;
	end

endmodule

// ==== verilog/bch_pkg.sv ====
`include "bch_macros.svh"

package bch_pkg;

	// ==================================================
	// Code-level types
	// ==================================================

	// Systematic layout, message in word[`BCH_N-1 -: `BCH_K], parity below
	typedef logic [`BCH_N-1:0] codeword_t;

	// S1 in the low nibble, S(2T) on top
	typedef logic [2*`BCH_T*`BCH_M-1:0] syndromes_t;

	// sigma0 in the low nibble
	typedef logic [(`BCH_T+1)*`BCH_M-1:0] sigma_t;

	// One spare code above T so an overlong locator shows up as a mismatch
	typedef logic [$clog2(`BCH_T+2)-1:0] err_count_t;

	typedef enum logic [1:0] {
		BMA_IDLE,
		BMA_ITERATE, // Discrepancy cycle
		BMA_UPDATE, // Locator and correction term update
		BMA_HOLD // Results held for the consumer
	} bma_state_t;

endpackage

// ==== verilog/gf_pkg.sv ====
`include "bch_macros.svh"

package gf_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	localparam logic [`BCH_M:0] PRIM_POLY = `BCH_PRIM_POLY;
	localparam int GF_ORDER = (1 << `BCH_M) - 1; // Nonzero elements

	// Multiply by alpha, reduce on overflow
	function automatic gf_elem_t gf_xtime(gf_elem_t a);
		gf_elem_t r;
		r = {a[`BCH_M-2:0], 1'b0};
		if (a[`BCH_M-1])
			r ^= PRIM_POLY[`BCH_M-1:0];
		return r;
	endfunction

	// Shift-and-add product
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t x;
		acc = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc ^= x;
			x = gf_xtime(x);
		end
		return acc;
	endfunction

	// alpha^idx, loop bound fixed so it maps to logic
	function automatic gf_elem_t gf_alpha_pow(int unsigned idx);
		gf_elem_t r;
		int unsigned e;
		r = gf_elem_t'(1);
		e = idx % GF_ORDER;
		for (int unsigned i = 0; i < GF_ORDER; i++)
			if (i < e)
				r = gf_xtime(r);
		return r;
	endfunction

endpackage

// ==== verilog/bch_macros.svh ====
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// ==================================================
// BCH(15,7) over GF(2^4), two-error correcting
// ==================================================

`define BCH_M 4 // Bits per field element
`define BCH_T 2 // Correctable errors
`define BCH_N 15 // Codeword length, 2^M - 1
`define BCH_K 7 // Message length

// x^4 + x + 1
`define BCH_PRIM_POLY 5'b10011

`endif
